// ==== source/sap_pkg.sv ====
`default_nettype none

package sap_pkg;

  // bus word, register contents and alu result
  typedef logic [7:0] word_t;

  // one 74ls283 or 74173 slice
  typedef logic [3:0] nibble_t;

  // flag register contents as seen by the rest of the machine
  typedef logic [1:0] flags_t;

  localparam int WORD_WIDTH = 8;  // data path width

  localparam int FLAG_CARRY = 0;  // carry out of the high adder
  localparam int FLAG_ZERO  = 1;  // result is all zeros

endpackage : sap_pkg

`default_nettype wire

// ==== source/dm74ls283_quad_adder.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm74ls283_quad_adder (
  input  sap_pkg::nibble_t a,     // operand a
  input  sap_pkg::nibble_t b,     // operand b
  input  logic             cin,   // carry into bit 0
  output sap_pkg::nibble_t sum,   // 4-bit sum
  output logic             cout   // carry out of bit 3
);

  import sap_pkg::*;

  nibble_t    prop;   // per-bit propagate
  nibble_t    gen;    // per-bit generate
  logic [4:0] carry;  // ripple chain, bit 0 is cin

  assign prop     = a ^ b;  // half-sum
  assign gen      = a & b;  // both ones
  assign carry[0] = cin;

  // ripple through the four stages like the real chip
  for (genvar i = 0; i < 4; i++) begin : g_ripple
    assign carry[i+1] = gen[i] | (prop[i] & carry[i]);  // carry into next stage
  end

  assign sum  = prop ^ carry[3:0];  // full-adder sum bits
  assign cout = carry[4];           // chains to the next adder

endmodule : dm74ls283_quad_adder

`default_nettype wire

// ==== source/sn54173_quad_flip_flop.sv ====
`timescale 1ns/10ps
`default_nettype none

module sn54173_quad_flip_flop (
  input  logic             clk,     // rising edge samples data
  input  logic             arst_n,  // system reset
  input  logic             g1,      // data enable, active low
  input  logic             g2,      // data enable, active low
  input  logic             clr,     // chip clear, active high
  input  sap_pkg::nibble_t data,    // d inputs
  output sap_pkg::nibble_t q        // latched outputs
);

  import sap_pkg::*;

  nibble_t next_q;  // value taken at the next edge

  // both enables must be low to load, otherwise recirculate
  always_comb begin
    if (!g1 && !g2) begin
      next_q = data;  // load
    end else begin
      next_q = q;     // hold
    end
  end

  // clr acts without a clock edge, as on the part
  always_ff @(posedge clk or negedge arst_n or posedge clr) begin
    if (!arst_n) begin
      q <= '0;  // system reset
    end else if (clr) begin
      q <= '0;  // chip clear
    end else begin
      q <= next_q;
    end
  end

  // a clear seen at one edge leaves q empty through the next
  assert property (
    @(posedge clk) disable iff (!arst_n)
    clr |=> (q == '0)
  ) else $error("sn54173: q not cleared after clr");

endmodule : sn54173_quad_flip_flop

`default_nettype wire

// ==== source/sap_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module sap_register (
  input  logic           clk,      // system clock
  input  logic           arst_n,   // clears the held word
  input  logic           load_n,   // load from bus, active low
  input  logic           out_n,    // drive bus, active low
  input  sap_pkg::word_t bus,      // shared bus contents
  output sap_pkg::word_t value,    // held word, straight to the alu
  output sap_pkg::word_t bus_out   // gated copy for the bus or
);

  import sap_pkg::*;

  nibble_t value_lo;  // bits 3..0
  nibble_t value_hi;  // bits 7..4

  // low nibble chip
  sn54173_quad_flip_flop reg_lo (
    .clk    (clk),
    .arst_n (arst_n),
    .g1     (load_n),     // both enables share the load strobe
    .g2     (load_n),
    .clr    (1'b0),       // no separate clear on operand registers
    .data   (bus[3:0]),
    .q      (value_lo)
  );

  // high nibble chip
  sn54173_quad_flip_flop reg_hi (
    .clk    (clk),
    .arst_n (arst_n),
    .g1     (load_n),
    .g2     (load_n),
    .clr    (1'b0),
    .data   (bus[7:4]),
    .q      (value_hi)
  );

  assign value = {value_hi, value_lo};  // rejoin the two chips

  // stands in for the 74245 transceiver, zeros when off
  assign bus_out = out_n ? '0 : value;

  // a load takes whatever sat on the bus at that edge
  assert property (
    @(posedge clk) disable iff (!arst_n)
    !load_n |=> (value == $past(bus))
  ) else $error("sap_register: load did not capture bus");

endmodule : sap_register

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  logic            clk,           // flag register clock
  input  logic            arst_n,        // clears the flags
  input  sap_pkg::word_t  a,             // from register a
  input  sap_pkg::word_t  b,             // from register b
  input  logic            bus_enable_n,  // result onto bus, active low
  input  logic            subtract,      // 1 = a - b
  input  logic            flag_fi_n,     // flag update, active low
  input  logic            flag_clear_n,  // flag clear, active low
  output sap_pkg::word_t  bus_out,       // gated result
  output sap_pkg::flags_t flag_out       // carry and zero
);

  import sap_pkg::*;

  word_t   b_eff;       // b or its ones' complement
  word_t   result;      // 8-bit sum from both adders
  logic    carry_mid;   // low adder into high adder
  logic    carry_out;   // out of bit 7
  logic    result_zero; // all result bits low
  nibble_t flag_data;   // d inputs of the flag chip
  nibble_t flag_q;      // flag chip outputs

  // xor stage in hardware, inverts b for subtraction
  assign b_eff = subtract ? ~b : b;

  // low nibble, subtract doubles as the +1 of two's complement
  dm74ls283_quad_adder adder_lo (
    .a    (a[3:0]),
    .b    (b_eff[3:0]),
    .cin  (subtract),
    .sum  (result[3:0]),
    .cout (carry_mid)
  );

  // high nibble
  dm74ls283_quad_adder adder_hi (
    .a    (a[7:4]),
    .b    (b_eff[7:4]),
    .cin  (carry_mid),
    .sum  (result[7:4]),
    .cout (carry_out)    // overflow on add, no borrow on sub
  );

  assign result_zero = (result == {WORD_WIDTH{1'b0}});  // zero detect

  assign flag_data[FLAG_CARRY] = carry_out;
  assign flag_data[FLAG_ZERO]  = result_zero;
  assign flag_data[3:2]        = 2'b00;  // spare flag bits

  // flags latch only when fi is low
  sn54173_quad_flip_flop flags_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .g1     (flag_fi_n),
    .g2     (flag_fi_n),
    .clr    (~flag_clear_n),  // chip clr is active high
    .data   (flag_data),
    .q      (flag_q)
  );

  assign flag_out = flag_q[1:0];  // top two bits unused

  assign bus_out = bus_enable_n ? '0 : result;  // off means zeros

  // disabled alu must not disturb the or-ed bus
  assert property (
    @(posedge clk) disable iff (!arst_n)
    bus_enable_n |-> (bus_out == '0)
  ) else $error("alu: bus_out not zero while disabled");

endmodule : alu

`default_nettype wire

// ==== source/alu_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_datapath (
  input  logic            clk,               // system clock
  input  logic            arst_n,            // async reset, active low
  input  sap_pkg::word_t  data_in,           // outside data
  input  logic            data_in_enable_n,  // outside data onto bus
  input  logic            a_load_n,          // bus into a
  input  logic            a_out_n,           // a onto bus
  input  logic            b_load_n,          // bus into b
  input  logic            b_out_n,           // b onto bus
  input  logic            sum_out_n,         // alu result onto bus
  input  logic            subtract,          // alu mode
  input  logic            flag_fi_n,         // latch flags
  input  logic            flag_clear_n,      // clear flags
  output sap_pkg::word_t  bus,               // shared bus
  output sap_pkg::flags_t flags              // carry and zero
);

  import sap_pkg::*;

  word_t data_bus;  // gated outside data
  word_t a_bus;     // a driver
  word_t b_bus;     // b driver
  word_t alu_bus;   // alu driver
  word_t a_value;   // a contents to alu
  word_t b_value;   // b contents to alu

  assign data_bus = data_in_enable_n ? '0 : data_in;  // extra bus driver

  // operand a
  sap_register a_reg (
    .clk     (clk),
    .arst_n  (arst_n),
    .load_n  (a_load_n),
    .out_n   (a_out_n),
    .bus     (bus),
    .value   (a_value),
    .bus_out (a_bus)
  );

  // operand b
  sap_register b_reg (
    .clk     (clk),
    .arst_n  (arst_n),
    .load_n  (b_load_n),
    .out_n   (b_out_n),
    .bus     (bus),
    .value   (b_value),
    .bus_out (b_bus)
  );

  // operands bypass the bus, result comes back on it
  alu alu_unit (
    .clk          (clk),
    .arst_n       (arst_n),
    .a            (a_value),
    .b            (b_value),
    .bus_enable_n (sum_out_n),
    .subtract     (subtract),
    .flag_fi_n    (flag_fi_n),
    .flag_clear_n (flag_clear_n),
    .bus_out      (alu_bus),
    .flag_out     (flags)
  );

  // every disabled driver gives zeros so a plain or merges them
  assign bus = data_bus | a_bus | b_bus | alu_bus;

  // two drivers at once would or their words together
  assert property (
    @(posedge clk) disable iff (!arst_n)
    $countones({~data_in_enable_n, ~a_out_n, ~b_out_n, ~sum_out_n}) <= 1
  ) else $error("alu_datapath: more than one bus driver enabled");

endmodule : alu_datapath

`default_nettype wire

// ==== test/alu_datapath_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_datapath_tb;

  import sap_pkg::*;

  localparam int CLK_PERIOD      = 4;                        // ns
  localparam int DRIVE_DELAY     = 1;                        // ns after the rising edge
  localparam int RESET_CYCLES    = 16;
  localparam int RANDOM_OPS      = 300;
  localparam int WATCHDOG_CYCLES = 200 + RANDOM_OPS * 12;    // fixed part plus random part

  localparam int SRC_A   = 0;  // bus source codes for read_source
  localparam int SRC_B   = 1;
  localparam int SRC_ALU = 2;

  logic   clk;
  logic   arst_n;
  word_t  data_in;
  logic   data_in_enable_n;
  logic   a_load_n;
  logic   a_out_n;
  logic   b_load_n;
  logic   b_out_n;
  logic   sum_out_n;
  logic   subtract;
  logic   flag_fi_n;
  logic   flag_clear_n;
  word_t  bus;
  flags_t flags;

  word_t  exp_a;       // model of register a
  word_t  exp_b;       // model of register b
  flags_t exp_flags;   // model of the flag register
  word_t  exp_result;  // a plus or minus b, mod 256
  logic   exp_carry;   // carry as the flag should take it
  word_t  exp_bus;     // what the or-ed bus should read

  int          bus_errors;
  int          carry_errors;
  int          zero_errors;
  int unsigned rnd;
  word_t       op_a;
  word_t       op_b;
  logic        op_sub;

  alu_datapath dut (
    .clk              (clk),
    .arst_n           (arst_n),
    .data_in          (data_in),
    .data_in_enable_n (data_in_enable_n),
    .a_load_n         (a_load_n),
    .a_out_n          (a_out_n),
    .b_load_n         (b_load_n),
    .b_out_n          (b_out_n),
    .sum_out_n        (sum_out_n),
    .subtract         (subtract),
    .flag_fi_n        (flag_fi_n),
    .flag_clear_n     (flag_clear_n),
    .bus              (bus),
    .flags            (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // reference arithmetic straight from the add/subtract rules
  always_comb begin
    if (subtract) begin
      exp_result = exp_a - exp_b;                   // wraps mod 256
      exp_carry  = (exp_a >= exp_b);                // no borrow
    end else begin
      exp_result = exp_a + exp_b;                   // wraps mod 256
      exp_carry  = (int'(exp_a) + int'(exp_b)) > 255;  // unsigned overflow
    end
  end

  // each disabled source reads as zeros
  assign exp_bus = (data_in_enable_n ? '0 : data_in)
                 | (a_out_n ? '0 : exp_a)
                 | (b_out_n ? '0 : exp_b)
                 | (sum_out_n ? '0 : exp_result);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_a <= '0;
      exp_b <= '0;
    end else begin
      if (!a_load_n) exp_a <= exp_bus;  // a takes the bus
      if (!b_load_n) exp_b <= exp_bus;
    end
  end

  // clear works without a clock, like the chip pin
  always_ff @(posedge clk or negedge arst_n or negedge flag_clear_n) begin
    if (!arst_n) begin
      exp_flags <= '0;
    end else if (!flag_clear_n) begin
      exp_flags <= '0;
    end else if (!flag_fi_n) begin
      exp_flags[FLAG_CARRY] <= exp_carry;
      exp_flags[FLAG_ZERO]  <= (exp_result == '0);
    end
  end

  // falling edge sits between input changes and register updates
  bus_matches: assert property (
    @(negedge clk) disable iff (!arst_n)
    bus == exp_bus
  ) else begin
    bus_errors = bus_errors + 1;
    $display("ERROR %0t bus expected %02h got %02h", $time, exp_bus, bus);
  end

  carry_matches: assert property (
    @(negedge clk) disable iff (!arst_n)
    flags[FLAG_CARRY] == exp_flags[FLAG_CARRY]
  ) else begin
    carry_errors = carry_errors + 1;
    $display("ERROR %0t flags[carry] expected %0b got %0b",
             $time, exp_flags[FLAG_CARRY], flags[FLAG_CARRY]);
  end

  zero_matches: assert property (
    @(negedge clk) disable iff (!arst_n)
    flags[FLAG_ZERO] == exp_flags[FLAG_ZERO]
  ) else begin
    zero_errors = zero_errors + 1;
    $display("ERROR %0t flags[zero] expected %0b got %0b",
             $time, exp_flags[FLAG_ZERO], flags[FLAG_ZERO]);
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // outside data onto the bus, one register samples it
  task automatic load_operand(input logic to_b, input word_t value);
    data_in          = value;
    data_in_enable_n = 1'b0;
    if (to_b) b_load_n = 1'b0;
    else a_load_n = 1'b0;
    next_cycle();
    data_in_enable_n = 1'b1;
    a_load_n         = 1'b1;
    b_load_n         = 1'b1;
  endtask

  task automatic read_source(input int source);
    case (source)
      SRC_A:   a_out_n   = 1'b0;
      SRC_B:   b_out_n   = 1'b0;
      default: sum_out_n = 1'b0;
    endcase
    next_cycle();
    a_out_n   = 1'b1;
    b_out_n   = 1'b1;
    sum_out_n = 1'b1;
  endtask

  task automatic run_alu(input word_t a_value, input word_t b_value, input logic sub);
    load_operand(1'b0, a_value);
    load_operand(1'b1, b_value);
    subtract  = sub;
    sum_out_n = 1'b0;  // result on the bus
    flag_fi_n = 1'b0;  // and into the flags
    next_cycle();
    sum_out_n = 1'b1;
    flag_fi_n = 1'b1;
    next_cycle();      // new flags settle for the checks
  endtask

  // result back into a, as the real machine does
  task automatic accumulate(input logic sub);
    subtract  = sub;
    sum_out_n = 1'b0;
    a_load_n  = 1'b0;
    next_cycle();
    sum_out_n = 1'b1;
    a_load_n  = 1'b1;
  endtask

  task automatic clear_flags();
    flag_clear_n = 1'b0;
    next_cycle();
    flag_clear_n = 1'b1;
    next_cycle();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    bus_errors       = 0;
    carry_errors     = 0;
    zero_errors      = 0;
    arst_n           = 1'b0;
    data_in          = '0;
    data_in_enable_n = 1'b1;
    a_load_n         = 1'b1;
    a_out_n          = 1'b1;
    b_load_n         = 1'b1;
    b_out_n          = 1'b1;
    sum_out_n        = 1'b1;
    subtract         = 1'b0;
    flag_fi_n        = 1'b1;
    flag_clear_n     = 1'b1;
    void'($urandom(34));

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // idle bus and cleared registers
    repeat (2) next_cycle();
    read_source(SRC_A);
    read_source(SRC_B);

    // load and read back, other register untouched
    load_operand(1'b0, 8'h5a);
    read_source(SRC_A);
    read_source(SRC_B);
    load_operand(1'b1, 8'hc3);
    read_source(SRC_A);
    read_source(SRC_B);

    // addition corners
    run_alu(8'h5a, 8'hc3, 1'b0);  // carry out
    run_alu(8'h10, 8'h20, 1'b0);
    run_alu(8'h80, 8'h80, 1'b0);  // carry and zero
    run_alu(8'hff, 8'h01, 1'b0);
    run_alu(8'h00, 8'h00, 1'b0);  // zero only

    // subtraction corners
    run_alu(8'h50, 8'h20, 1'b0);
    run_alu(8'h50, 8'h20, 1'b1);  // no borrow
    run_alu(8'h20, 8'h50, 1'b1);  // borrow
    run_alu(8'h77, 8'h77, 1'b1);  // equal operands
    run_alu(8'h00, 8'h01, 1'b1);

    // flags hold while operands and mode change
    run_alu(8'hff, 8'h01, 1'b0);
    load_operand(1'b0, 8'h12);
    load_operand(1'b1, 8'h34);
    subtract = 1'b0;
    read_source(SRC_ALU);
    subtract = 1'b1;
    read_source(SRC_ALU);
    repeat (3) next_cycle();
    clear_flags();

    // running total kept in a
    run_alu(8'h05, 8'h03, 1'b0);
    accumulate(1'b0);
    read_source(SRC_A);
    accumulate(1'b0);
    read_source(SRC_A);
    accumulate(1'b1);
    read_source(SRC_A);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rnd    = $urandom;
      op_a   = rnd[WORD_WIDTH-1:0];
      rnd    = $urandom;
      op_b   = rnd[WORD_WIDTH-1:0];
      rnd    = $urandom;
      op_sub = rnd[0];
      run_alu(op_a, op_b, op_sub);
      read_source(SRC_ALU);  // result again, flags now updated
    end

    repeat (3) next_cycle();
    $display("errors: bus %0d, carry flag %0d, zero flag %0d",
             bus_errors, carry_errors, zero_errors);
    if (bus_errors + carry_errors + zero_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : alu_datapath_tb

`default_nettype wire

// ==== src.f ====
source/sap_pkg.sv
source/dm74ls283_quad_adder.sv
source/sn54173_quad_flip_flop.sv
source/sap_register.sv
source/alu.sv
source/alu_datapath.sv
test/alu_datapath_tb.sv

// ==== Makefile ====
TOP = alu_datapath_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

obj_dir/V$(TOP): src.f source/*.sv test/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
